/* verilog/rv_pkg.sv */
package rv_pkg;

  // widths
  localparam int xlen    = 32;
  localparam int reg_cnt = 32;

  typedef logic [xlen-1:0]            word_t;
  typedef logic [$clog2(reg_cnt)-1:0] reg_addr_t;
  typedef logic [6:0]                 opcode_t;
  typedef logic [2:0]                 funct3_t;

  localparam word_t reset_pc = 32'h8000_0000; // first fetch address

  // major opcodes
  localparam opcode_t op_reg    = 7'b011_0011;
  localparam opcode_t op_imm    = 7'b001_0011;
  localparam opcode_t op_lui    = 7'b011_0111;
  localparam opcode_t op_auipc  = 7'b001_0111;
  localparam opcode_t op_jal    = 7'b110_1111;
  localparam opcode_t op_jalr   = 7'b110_0111;
  localparam opcode_t op_branch = 7'b110_0011;
  localparam opcode_t op_store  = 7'b010_0011; // decoded, never written back

  // alu funct3
  localparam funct3_t f3_add  = 3'b000; // add, sub, addi
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101; // srl / sra by alt
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // branch funct3
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // decoder output, one per instruction
  typedef struct packed {
    opcode_t   opcode;
    funct3_t   funct3;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      alt;       // funct7[5], sub / sra
    word_t     imm;       // already in the format of the opcode
    logic      reg_write;
  } decoded_t;

  // register write, also shown outside the core
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } wb_t;

endpackage

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
  import rv_pkg::*;
(
  input  word_t    inst,
  output decoded_t dec
);

  opcode_t opcode;
  funct3_t funct3;
  logic    is_shift;

  // candidate immediates, one per format
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t imm_shamt;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  assign is_shift = (funct3 == f3_sll) || (funct3 == f3_sr);

  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // slli/srli/srai only use the low five bits
  assign imm_shamt = {{(xlen-5){1'b0}}, inst[24:20]};

  always_comb begin
    dec.opcode = opcode;
    dec.funct3 = funct3;
    dec.rd     = inst[11:7];
    dec.rs1    = inst[19:15];
    dec.rs2    = inst[24:20];

    // immediate by format
    case (opcode)
      op_imm:    dec.imm = is_shift ? imm_shamt : imm_i;
      op_jalr:   dec.imm = imm_i;
      op_store:  dec.imm = imm_s;
      op_branch: dec.imm = imm_b;
      op_lui,
      op_auipc:  dec.imm = imm_u;
      op_jal:    dec.imm = imm_j;
      default:   dec.imm = '0; // R type and unknown opcodes
    endcase

    // funct7[5] only matters for sub, sra and srai
    dec.alt = 1'b0;
    if (opcode == op_reg) begin
      dec.alt = inst[30] && ((funct3 == f3_add) || (funct3 == f3_sr));
    end else if (opcode == op_imm) begin
      dec.alt = inst[30] && (funct3 == f3_sr);
    end

    // stores, branches and anything unknown write nothing
    case (opcode)
      op_reg,
      op_imm,
      op_lui,
      op_auipc,
      op_jal,
      op_jalr:  dec.reg_write = 1'b1;
      default:  dec.reg_write = 1'b0;
    endcase
  end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  wb_t       wb
);

  word_t regs [reg_cnt];

  logic do_write;

  // x0 is never stored
  assign do_write = rst_n && wb.en && (wb.addr != '0);

  always_ff @(posedge clk) begin
    if (do_write) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // combinational reads, x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* verilog/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
  import rv_pkg::*;
(
  input  logic     rst_n,
  input  decoded_t dec,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output wb_t      wb
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       sub_op;
  word_t      alu_res;
  word_t      wb_data;

  assign op_a  = rs1_data;
  assign op_b  = (dec.opcode == op_reg) ? rs2_data : dec.imm; // reg or immediate
  assign shamt = op_b[4:0];

  // addi has no subtract form
  assign sub_op = dec.alt && (dec.opcode == op_reg);

  always_comb begin
    case (dec.funct3)
      f3_add:  alu_res = sub_op ? (op_a - op_b) : (op_a + op_b);
      f3_sll:  alu_res = op_a << shamt;
      f3_slt:  alu_res = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
      f3_sltu: alu_res = (op_a < op_b) ? word_t'(1) : '0;
      f3_xor:  alu_res = op_a ^ op_b;
      f3_sr: begin
        if (dec.alt) begin
          alu_res = word_t'($signed(op_a) >>> shamt); // keeps the sign
        end else begin
          alu_res = op_a >> shamt;
        end
      end
      f3_or:   alu_res = op_a | op_b;
      f3_and:  alu_res = op_a & op_b;
      default: alu_res = '0;
    endcase
  end

  // write-back value by opcode
  always_comb begin
    case (dec.opcode)
      op_reg,
      op_imm:   wb_data = alu_res;
      op_lui:   wb_data = dec.imm;
      op_auipc: wb_data = pc + dec.imm;
      op_jal,
      op_jalr:  wb_data = pc + word_t'(4); // link address
      default:  wb_data = '0;
    endcase
  end

  always_comb begin
    wb.en   = dec.reg_write && rst_n; // quiet while in reset
    wb.addr = dec.rd;
    wb.data = wb_data;
  end

endmodule

/* verilog/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  decoded_t dec,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output word_t    pc
);

  logic  is_eq;
  logic  is_lt;
  logic  is_ltu;
  logic  taken;
  word_t pc_plus4;
  word_t pc_rel;
  word_t jalr_sum;
  word_t next_pc;

  // branch comparator
  assign is_eq  = (rs1_data == rs2_data);
  assign is_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign is_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (dec.funct3)
      f3_beq:  taken = is_eq;
      f3_bne:  taken = !is_eq;
      f3_blt:  taken = is_lt;
      f3_bge:  taken = !is_lt;
      f3_bltu: taken = is_ltu;
      f3_bgeu: taken = !is_ltu;
      default: taken = 1'b0; // reserved encodings fall through
    endcase
  end

  assign pc_plus4 = pc + word_t'(4);
  assign pc_rel   = pc + dec.imm; // B or J immediate from the decoder
  assign jalr_sum = rs1_data + dec.imm;

  always_comb begin
    case (dec.opcode)
      op_branch: next_pc = taken ? pc_rel : pc_plus4;
      op_jal:    next_pc = pc_rel;
      op_jalr:   next_pc = {jalr_sum[xlen-1:1], 1'b0}; // lsb cleared
      default:   next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  word_t inst,
  output word_t pc,
  output wb_t   wb
);

  decoded_t dec;
  word_t    rs1_data;
  word_t    rs2_data;

  inst_decoder inst_decoder_inst (
    .inst (inst),
    .dec  (dec)
  );

  // write port is fed straight from the write-back bundle
  reg_file reg_file_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  execute_unit execute_unit_inst (
    .rst_n    (rst_n),
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  pc_unit pc_unit_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc)
  );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  localparam time half_period = 5ns; // 10 ns clock

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

/* verification/rv_core_checker.sv */
`timescale 1ns/1ps

module rv_core_checker
  import rv_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input word_t inst,
  input word_t pc,
  input wb_t   wb
);

  int unsigned error_count = 0; // read by the testbench at the end

  opcode_t opcode;

  assign opcode = inst[6:0];

  // fetch address stays on a word boundary
  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else begin
      $error("pc is not a multiple of 4: %h", pc);
      error_count++;
    end

  quiet_after_reset: assert property (@(posedge clk) !$past(rst_n) |-> !wb.en)
    else begin
      $error("write-back enabled right after reset");
      error_count++;
    end

  no_branch_write: assert property (@(posedge clk) (opcode == op_branch) |-> !wb.en)
    else begin
      $error("branch instruction enabled a register write");
      error_count++;
    end

endmodule

bind rv_core rv_core_checker rv_core_checker_inst (
  .clk   (clk),
  .rst_n (rst_n),
  .inst  (inst),
  .pc    (pc),
  .wb    (wb)
);

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb
  import rv_pkg::*;
();

  localparam int  clk_period   = 10;
  localparam int  reset_cycles = 16;
  localparam time drive_delay  = 1ns;

  // opcodes as the ISA manual lists them
  localparam logic [6:0] opc_reg    = 7'b0110011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  typedef struct packed {
    word_t     pc;   // expected pc in this cycle
    word_t     inst;
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } row_t;

  logic  clk;
  logic  rst_n;
  word_t inst;
  word_t pc;
  wb_t   wb;

  row_t rows[$];
  logic rows_ready = 1'b0;
  int   cyc;

  tb_clock_gen tb_clock_gen_inst (
    .clk (clk)
  );

  rv_core rv_core_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .inst  (inst),
    .pc    (pc),
    .wb    (wb)
  );

  function automatic word_t enc_r(logic alt, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd);
    return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  task automatic push_row(input word_t exp_pc, input word_t code, input logic en,
                          input reg_addr_t addr, input word_t data);
    row_t r;
    r.pc   = exp_pc;
    r.inst = code;
    r.en   = en;
    r.addr = addr;
    r.data = data;
    rows.push_back(r);
  endtask

  // x1 = 5, x2 = -3 are the main operands
  task automatic build_table();
    push_row(32'h8000_0000, enc_s(12'd0, 5'd0, 5'd0, 3'b010), 1'b0, 5'd0, '0); // sw
    push_row(32'h8000_0004, enc_i(12'd5, 5'd0, 3'b000, 5'd1, opc_imm), 1'b1, 5'd1, 32'h5);
    push_row(32'h8000_0008, enc_i(12'hFFD, 5'd0, 3'b000, 5'd2, opc_imm), 1'b1, 5'd2,
             32'hFFFF_FFFD);                                                  // addi -3
    push_row(32'h8000_000C, enc_i(12'h00F, 5'd1, 3'b100, 5'd3, opc_imm), 1'b1, 5'd3, 32'hA);
    push_row(32'h8000_0010, enc_i(12'h030, 5'd1, 3'b110, 5'd4, opc_imm), 1'b1, 5'd4, 32'h35);
    push_row(32'h8000_0014, enc_i(12'h0F0, 5'd2, 3'b111, 5'd5, opc_imm), 1'b1, 5'd5, 32'hF0);
    push_row(32'h8000_0018, enc_i(12'd4, 5'd1, 3'b001, 5'd6, opc_imm), 1'b1, 5'd6, 32'h50);
    push_row(32'h8000_001C, enc_i(12'd28, 5'd2, 3'b101, 5'd7, opc_imm), 1'b1, 5'd7, 32'hF);
    push_row(32'h8000_0020, enc_i(12'h401, 5'd2, 3'b101, 5'd8, opc_imm), 1'b1, 5'd8,
             32'hFFFF_FFFE);                                                  // srai
    push_row(32'h8000_0024, enc_i(12'd1, 5'd2, 3'b010, 5'd9, opc_imm), 1'b1, 5'd9, 32'h1);
    push_row(32'h8000_0028, enc_i(12'd1, 5'd2, 3'b011, 5'd10, opc_imm), 1'b1, 5'd10, 32'h0);
    push_row(32'h8000_002C, enc_u(20'h12345, 5'd11, opc_lui), 1'b1, 5'd11, 32'h1234_5000);
    push_row(32'h8000_0030, enc_u(20'h00001, 5'd12, opc_auipc), 1'b1, 5'd12, 32'h8000_1030);
    push_row(32'h8000_0034, enc_r(1'b0, 5'd2, 5'd1, 3'b000, 5'd13), 1'b1, 5'd13, 32'h2);
    push_row(32'h8000_0038, enc_r(1'b1, 5'd2, 5'd1, 3'b000, 5'd14), 1'b1, 5'd14, 32'h8);
    push_row(32'h8000_003C, enc_r(1'b0, 5'd6, 5'd4, 3'b111, 5'd15), 1'b1, 5'd15, 32'h10);
    push_row(32'h8000_0040, enc_r(1'b0, 5'd4, 5'd3, 3'b110, 5'd16), 1'b1, 5'd16, 32'h3F);
    push_row(32'h8000_0044, enc_r(1'b0, 5'd6, 5'd4, 3'b100, 5'd17), 1'b1, 5'd17, 32'h65);
    push_row(32'h8000_0048, enc_r(1'b0, 5'd1, 5'd1, 3'b001, 5'd18), 1'b1, 5'd18, 32'hA0);
    push_row(32'h8000_004C, enc_r(1'b0, 5'd1, 5'd2, 3'b101, 5'd19), 1'b1, 5'd19,
             32'h07FF_FFFF);
    push_row(32'h8000_0050, enc_r(1'b1, 5'd1, 5'd2, 3'b101, 5'd20), 1'b1, 5'd20,
             32'hFFFF_FFFF);
    push_row(32'h8000_0054, enc_r(1'b0, 5'd1, 5'd2, 3'b010, 5'd21), 1'b1, 5'd21, 32'h1);
    push_row(32'h8000_0058, enc_r(1'b0, 5'd1, 5'd2, 3'b011, 5'd22), 1'b1, 5'd22, 32'h0);
    push_row(32'h8000_005C, enc_i(12'd7, 5'd1, 3'b000, 5'd0, opc_imm), 1'b1, 5'd0, 32'hC);
    push_row(32'h8000_0060, enc_r(1'b0, 5'd1, 5'd0, 3'b000, 5'd23), 1'b1, 5'd23, 32'h5);
    // branches, each row's pc shows whether the previous one was taken
    push_row(32'h8000_0064, enc_b(13'd8, 5'd1, 5'd1, 3'b000), 1'b0, 5'd0, '0); // beq t
    push_row(32'h8000_006C, enc_b(13'd8, 5'd2, 5'd1, 3'b000), 1'b0, 5'd0, '0); // beq n
    push_row(32'h8000_0070, enc_b(13'd8, 5'd2, 5'd1, 3'b001), 1'b0, 5'd0, '0); // bne t
    push_row(32'h8000_0078, enc_b(13'd8, 5'd1, 5'd1, 3'b001), 1'b0, 5'd0, '0); // bne n
    push_row(32'h8000_007C, enc_b(13'd8, 5'd1, 5'd2, 3'b100), 1'b0, 5'd0, '0); // blt t
    push_row(32'h8000_0084, enc_b(13'd8, 5'd2, 5'd1, 3'b100), 1'b0, 5'd0, '0); // blt n
    push_row(32'h8000_0088, enc_b(13'd8, 5'd2, 5'd1, 3'b101), 1'b0, 5'd0, '0); // bge t
    push_row(32'h8000_0090, enc_b(13'd8, 5'd1, 5'd2, 3'b101), 1'b0, 5'd0, '0); // bge n
    push_row(32'h8000_0094, enc_b(13'd8, 5'd2, 5'd1, 3'b110), 1'b0, 5'd0, '0); // bltu t
    push_row(32'h8000_009C, enc_b(13'd8, 5'd1, 5'd2, 3'b110), 1'b0, 5'd0, '0); // bltu n
    push_row(32'h8000_00A0, enc_b(13'd8, 5'd1, 5'd2, 3'b111), 1'b0, 5'd0, '0); // bgeu t
    push_row(32'h8000_00A8, enc_b(13'd8, 5'd2, 5'd1, 3'b111), 1'b0, 5'd0, '0); // bgeu n
    push_row(32'h8000_00AC, enc_s(12'd4, 5'd1, 5'd0, 3'b010), 1'b0, 5'd0, '0); // sw
    // jumps
    push_row(32'h8000_00B0, enc_j(21'd16, 5'd24), 1'b1, 5'd24, 32'h8000_00B4);
    push_row(32'h8000_00C0, enc_i(12'h021, 5'd24, 3'b000, 5'd25, opc_jalr), 1'b1, 5'd25,
             32'h8000_00C4);                                  // odd sum B4 + 21
    push_row(32'h8000_00D4, enc_j(21'h1F_FFC0, 5'd27), 1'b1, 5'd27, 32'h8000_00D8); // -64
    push_row(32'h8000_0094, enc_i(12'd4, 5'd27, 3'b000, 5'd28, opc_imm), 1'b1, 5'd28,
             32'h8000_00DC);
    push_row(32'h8000_0098, enc_r(1'b0, 5'd25, 5'd24, 3'b000, 5'd29), 1'b1, 5'd29,
             32'h0000_0178);                                  // wraps past 2^32
    push_row(32'h8000_009C, enc_r(1'b1, 5'd1, 5'd29, 3'b000, 5'd30), 1'b1, 5'd30,
             32'h0000_0173);
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("tests failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  initial begin
    wait (rows_ready);
    #((reset_cycles + rows.size() + 10) * clk_period * 1ns);
    $display("watchdog expired before the table was finished");
    $display("tests failed");
    $fatal(1, "run timed out");
  end

  initial begin
    rst_n = 1'b0;
    inst  = '0;
    build_table();
    rows_ready = 1'b1;

    // last reset edge is taken by the first table row
    for (cyc = 0; cyc < reset_cycles - 1; cyc++) begin
      @(posedge clk);
      #(drive_delay);
      inst = enc_i(12'd1, 5'd0, 3'b000, 5'd1, opc_imm); // would write x1
      #(drive_delay);
      check_value("wb.en", word_t'(wb.en), '0);
    end

    foreach (rows[r]) begin
      @(posedge clk);
      #(drive_delay);
      rst_n = 1'b1;
      inst  = rows[r].inst;
      #(drive_delay);
      check_value("pc", pc, rows[r].pc);
      check_value("wb.en", word_t'(wb.en), word_t'(rows[r].en));
      if (rows[r].en) begin
        check_value("wb.addr", word_t'(wb.addr), word_t'(rows[r].addr));
        check_value("wb.data", wb.data, rows[r].data);
      end
    end

    @(posedge clk); // lets the last cycle reach the checker
    #(drive_delay);
    if (rv_core_inst.rv_core_checker_inst.error_count != 0) begin
      $display("checker assertions failed %0d times",
               rv_core_inst.rv_core_checker_inst.error_count);
      $display("tests failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* src.f */
verilog/rv_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/pc_unit.sv
verilog/rv_core.sv
verification/tb_clock_gen.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/inst_decoder.sv
      - verilog/reg_file.sv
      - verilog/execute_unit.sv
      - verilog/pc_unit.sv
      - verilog/rv_core.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/rv_core_checker.sv
      - verification/rv_core_tb.sv
